//--- tb.f
design/net_pkg.sv
design/comm_pkg.sv
design/collective_ifs.sv
design/comm_registry.sv
design/contribution_gatherer.sv
design/reduction_forwarder.sv
design/collective_node.sv
test/collective_node_properties.sv
test/collective_node_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := collective_node_tb
FILELIST   := tb.f
OBJ_DIR    := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing --assert -Wno-fatal -j 0 --Mdir $(OBJ_DIR)
LINT_FLAGS := --lint-only --timing -Wall
PASS_TEXT  := All tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "Simulation PASSED"; \
	else \
		echo "Simulation FAILED"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- test/collective_node_tb.sv
`timescale 1ns/1ps
`default_nettype none

module collective_node_tb;

	////////////////////////////////////////
	// Timing and run budget
	////////////////////////////////////////

	localparam int clk_period = 8;
	localparam int reset_cycles = 10;
	// Cycle budget per directed test, idle gap included
	localparam int len_nonroot = 10;
	localparam int len_allreduce = 10;
	localparam int len_back_to_back = 10;
	localparam int len_foreign_ctx = 10;
	localparam int len_bad_op = 10;
	localparam int len_bad_config = 10;
	localparam int total_cycles = reset_cycles + len_nonroot + len_allreduce +
		len_back_to_back + len_foreign_ctx + len_bad_op + len_bad_config;
	localparam int timeout_ns = 2 * total_cycles * clk_period;

	logic clk;
	logic rst_n;
	logic comm_load;
	logic [net_pkg::context_w-1:0] comm_context_id;
	logic [comm_pkg::rank_w-1:0] comm_root;
	logic [comm_pkg::rank_w-1:0] comm_local_rank;
	logic [comm_pkg::children_w-1:0] comm_children;
	logic local_valid;
	net_pkg::collective_op_e local_op;
	logic [net_pkg::context_w-1:0] local_context_id;
	logic [net_pkg::seq_w-1:0] local_seq;
	logic [net_pkg::payload_w-1:0] local_payload;
	logic child_valid;
	net_pkg::collective_op_e child_op;
	logic [net_pkg::context_w-1:0] child_context_id;
	logic [net_pkg::seq_w-1:0] child_seq;
	logic [net_pkg::payload_w-1:0] child_payload;
	logic up_valid;
	net_pkg::collective_op_e up_op;
	logic [net_pkg::seq_w-1:0] up_seq;
	logic [net_pkg::payload_w-1:0] up_payload;
	logic result_valid;
	logic [net_pkg::seq_w-1:0] result_seq;
	logic [net_pkg::payload_w-1:0] result_payload;
	logic bcast_valid;
	logic [net_pkg::seq_w-1:0] bcast_seq;
	logic [net_pkg::payload_w-1:0] bcast_payload;
	logic error_valid;
	net_pkg::node_error_e error_code;

	integer seed;
	int value_errors;
	int strobe_errors;

	collective_node DUT (.*);

	// Free-running clock
	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////

	// One cycle on, strobes dropped at the next falling edge
	task automatic tick();
		@(negedge clk);
		comm_load = 1'b0;
		local_valid = 1'b0;
		child_valid = 1'b0;
	endtask

	task automatic load_context(
		input logic [net_pkg::context_w-1:0] ctx_id,
		input logic [comm_pkg::rank_w-1:0] root,
		input logic [comm_pkg::rank_w-1:0] rank,
		input logic [comm_pkg::children_w-1:0] children
	);
		comm_load = 1'b1;
		comm_context_id = ctx_id;
		comm_root = root;
		comm_local_rank = rank;
		comm_children = children;
		tick();
	endtask

	task automatic set_local(
		input net_pkg::collective_op_e op,
		input logic [net_pkg::context_w-1:0] ctx_id,
		input logic [net_pkg::seq_w-1:0] seq,
		input logic [net_pkg::payload_w-1:0] payload
	);
		local_valid = 1'b1;
		local_op = op;
		local_context_id = ctx_id;
		local_seq = seq;
		local_payload = payload;
	endtask

	task automatic set_child(
		input net_pkg::collective_op_e op,
		input logic [net_pkg::context_w-1:0] ctx_id,
		input logic [net_pkg::seq_w-1:0] seq,
		input logic [net_pkg::payload_w-1:0] payload
	);
		child_valid = 1'b1;
		child_op = op;
		child_context_id = ctx_id;
		child_seq = seq;
		child_payload = payload;
	endtask

	////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////

	task automatic value_mismatch(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		$display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
		value_errors++;
	endtask

	task automatic check_up(
		input net_pkg::collective_op_e exp_op,
		input logic [net_pkg::seq_w-1:0] exp_seq,
		input logic [net_pkg::payload_w-1:0] exp_payload
	);
		if (!up_valid) begin
			$display("At %0t the up packet did not arrive", $time);
			strobe_errors++;
		end else begin
			if (up_op != exp_op) begin
				value_mismatch("up_op", 32'(up_op), 32'(exp_op));
			end
			if (up_seq != exp_seq) begin
				value_mismatch("up_seq", 32'(up_seq), 32'(exp_seq));
			end
			if (up_payload != exp_payload) begin
				value_mismatch("up_payload", up_payload, exp_payload);
			end
		end
	endtask

	task automatic check_result(
		input logic [net_pkg::seq_w-1:0] exp_seq,
		input logic [net_pkg::payload_w-1:0] exp_payload
	);
		if (!result_valid) begin
			$display("At %0t the root result did not arrive", $time);
			strobe_errors++;
		end else begin
			if (result_seq != exp_seq) begin
				value_mismatch("result_seq", 32'(result_seq), 32'(exp_seq));
			end
			if (result_payload != exp_payload) begin
				value_mismatch("result_payload", result_payload, exp_payload);
			end
		end
	endtask

	task automatic check_bcast(
		input logic [net_pkg::seq_w-1:0] exp_seq,
		input logic [net_pkg::payload_w-1:0] exp_payload
	);
		if (!bcast_valid) begin
			$display("At %0t the broadcast packet did not arrive", $time);
			strobe_errors++;
		end else begin
			if (bcast_seq != exp_seq) begin
				value_mismatch("bcast_seq", 32'(bcast_seq), 32'(exp_seq));
			end
			if (bcast_payload != exp_payload) begin
				value_mismatch("bcast_payload", bcast_payload, exp_payload);
			end
		end
	endtask

	task automatic check_error(input net_pkg::node_error_e exp_code);
		if (!error_valid) begin
			$display("At %0t the %s error strobe did not arrive", $time, exp_code.name());
			strobe_errors++;
		end else if (error_code != exp_code) begin
			$display("** Error at %0t: error_code is %s, expected %s", $time,
				error_code.name(), exp_code.name());
			value_errors++;
		end
		// An aborted reduction must not leave the node
		if (up_valid || result_valid) begin
			$display("At %0t a packet was sent along with an error", $time);
			strobe_errors++;
		end
	endtask

	// Nothing may leave the node in this cycle
	task automatic quiet_outputs(input string where);
		if (up_valid || result_valid || bcast_valid || error_valid) begin
			$display("At %0t an output strobe was high %s", $time, where);
			strobe_errors++;
		end
		if (error_code != net_pkg::err_none) begin
			$display("** Error at %0t: error_code is %s %s, expected err_none", $time,
				error_code.name(), where);
			value_errors++;
		end
	endtask

	task automatic no_up_packet(input string where);
		if (up_valid) begin
			$display("At %0t an up packet was sent %s", $time, where);
			strobe_errors++;
		end
	endtask

	////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////

	// Rank 1 under root 0, two children
	task automatic nonroot_reduce();
		logic [net_pkg::payload_w-1:0] a;
		logic [net_pkg::payload_w-1:0] b;
		logic [net_pkg::payload_w-1:0] c;
		a = $random(seed);
		b = $random(seed);
		c = $random(seed);
		load_context(8'h21, 9'd0, 9'd1, 3'd2);
		set_local(net_pkg::op_short_reduce, 8'h21, 8'h10, a);
		tick();
		set_child(net_pkg::op_short_reduce, 8'h21, 8'h10, b);
		tick();
		set_child(net_pkg::op_short_reduce, 8'h21, 8'h10, c);
		tick();
		quiet_outputs("one cycle after the last contribution");
		tick();
		// Wrapping 32-bit sum
		check_up(net_pkg::op_short_reduce, 8'h10, a + b + c);
		tick();
		quiet_outputs("after the up packet");
	endtask

	// Root with three children, local and first child together
	task automatic root_allreduce();
		logic [net_pkg::payload_w-1:0] a;
		logic [net_pkg::payload_w-1:0] b;
		logic [net_pkg::payload_w-1:0] c;
		logic [net_pkg::payload_w-1:0] d;
		a = $random(seed);
		b = $random(seed);
		c = $random(seed);
		d = $random(seed);
		load_context(8'h5a, 9'd5, 9'd5, 3'd3);
		set_local(net_pkg::op_short_allreduce, 8'h5a, 8'h20, a);
		set_child(net_pkg::op_short_allreduce, 8'h5a, 8'h20, b);
		tick();
		set_child(net_pkg::op_short_allreduce, 8'h5a, 8'h20, c);
		tick();
		set_child(net_pkg::op_short_allreduce, 8'h5a, 8'h20, d);
		tick();
		quiet_outputs("before the root result");
		tick();
		check_result(8'h20, a + b + c + d);
		check_bcast(8'h20, a + b + c + d);
		no_up_packet("at the root");
		tick();
	endtask

	// Next reduction starts in the completion cycle of the previous one
	task automatic back_to_back();
		logic [net_pkg::payload_w-1:0] a;
		logic [net_pkg::payload_w-1:0] b;
		logic [net_pkg::payload_w-1:0] c;
		logic [net_pkg::payload_w-1:0] d;
		a = $random(seed);
		b = $random(seed);
		c = $random(seed);
		d = $random(seed);
		load_context(8'h33, 9'd0, 9'd2, 3'd1);
		set_local(net_pkg::op_short_reduce, 8'h33, 8'h30, a);
		tick();
		set_child(net_pkg::op_short_reduce, 8'h33, 8'h30, b);
		tick();
		set_local(net_pkg::op_short_reduce, 8'h33, 8'h31, c);
		tick();
		check_up(net_pkg::op_short_reduce, 8'h30, a + b);
		set_child(net_pkg::op_short_reduce, 8'h33, 8'h31, d);
		tick();
		quiet_outputs("between the two up packets");
		tick();
		check_up(net_pkg::op_short_reduce, 8'h31, c + d);
		tick();
	endtask

	// Context 0x33 still loaded, one child
	task automatic foreign_context();
		logic [net_pkg::payload_w-1:0] a;
		logic [net_pkg::payload_w-1:0] b;
		logic [net_pkg::payload_w-1:0] c;
		a = $random(seed);
		b = $random(seed);
		c = $random(seed);
		set_child(net_pkg::op_short_reduce, 8'h77, 8'h40, a);
		tick();
		quiet_outputs("before the context error");
		tick();
		check_error(net_pkg::err_bad_context);
		// Clean reduction, aborted payload must be gone
		set_local(net_pkg::op_short_reduce, 8'h33, 8'h41, b);
		tick();
		set_child(net_pkg::op_short_reduce, 8'h33, 8'h41, c);
		tick();
		quiet_outputs("one cycle after the last contribution");
		tick();
		check_up(net_pkg::op_short_reduce, 8'h41, b + c);
		tick();
	endtask

	task automatic bad_op_and_seq();
		logic [net_pkg::payload_w-1:0] a;
		logic [net_pkg::payload_w-1:0] b;
		logic [net_pkg::payload_w-1:0] c;
		a = $random(seed);
		b = $random(seed);
		c = $random(seed);
		// Scan is not handled here
		set_local(net_pkg::op_scan, 8'h33, 8'h50, a);
		tick();
		quiet_outputs("before the opcode error");
		tick();
		check_error(net_pkg::err_bad_op);
		// Second arrival with another seq
		set_local(net_pkg::op_short_reduce, 8'h33, 8'h51, b);
		tick();
		set_child(net_pkg::op_short_reduce, 8'h33, 8'h52, c);
		tick();
		quiet_outputs("before the seq mismatch error");
		tick();
		check_error(net_pkg::err_bad_op);
		no_up_packet("for a mismatched seq");
		tick();
	endtask

	// Seven children exceeds the torus fan-in
	task automatic bad_config();
		logic [net_pkg::payload_w-1:0] a;
		logic [net_pkg::payload_w-1:0] b;
		a = $random(seed);
		b = $random(seed);
		load_context(8'h44, 9'd3, 9'd3, 3'd7);
		quiet_outputs("one cycle after the rejected load");
		tick();
		check_error(net_pkg::err_bad_config);
		// Old context, non-root with one child
		set_local(net_pkg::op_short_reduce, 8'h33, 8'h60, a);
		tick();
		set_child(net_pkg::op_short_reduce, 8'h33, 8'h60, b);
		tick();
		quiet_outputs("one cycle after the last contribution");
		tick();
		check_up(net_pkg::op_short_reduce, 8'h60, a + b);
		tick();
	endtask

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////

	initial begin
		seed = 32'hd586b85d;
		value_errors = 0;
		strobe_errors = 0;
		rst_n = 1'b0;
		comm_load = 1'b0;
		comm_context_id = '0;
		comm_root = '0;
		comm_local_rank = '0;
		comm_children = '0;
		local_valid = 1'b0;
		local_op = net_pkg::op_short_reduce;
		local_context_id = '0;
		local_seq = '0;
		local_payload = '0;
		child_valid = 1'b0;
		child_op = net_pkg::op_short_reduce;
		child_context_id = '0;
		child_seq = '0;
		child_payload = '0;
		repeat (reset_cycles) @(negedge clk);
		quiet_outputs("at the end of reset");
		rst_n = 1'b1;
		tick();
		nonroot_reduce();
		root_allreduce();
		back_to_back();
		foreign_context();
		bad_op_and_seq();
		bad_config();
		$display("Summary: %0d value errors, %0d strobe errors", value_errors, strobe_errors);
		if (value_errors + strobe_errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#(timeout_ns);
		$display("Watchdog expired: tests still running after %0d ns", timeout_ns);
		$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- test/collective_node_properties.sv
`timescale 1ns/1ps
`default_nettype none

module collective_node_properties (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic up_valid,
	input wire logic result_valid,
	input wire logic bcast_valid,
	input wire logic error_valid,
	input wire net_pkg::node_error_e error_code
);

	// Strobes cleared one edge into reset
	property quiet_in_reset;
		@(posedge clk) !rst_n |=> (!up_valid && !result_valid && !bcast_valid &&
			!error_valid && error_code == net_pkg::err_none);
	endproperty

	// Root delivers, others send up, never both
	property up_or_result;
		@(posedge clk) disable iff (!rst_n) !(up_valid && result_valid);
	endproperty

	// Broadcast only alongside the root result
	property bcast_with_result;
		@(posedge clk) disable iff (!rst_n) bcast_valid |-> result_valid;
	endproperty

	property error_has_code;
		@(posedge clk) disable iff (!rst_n) error_valid |-> error_code != net_pkg::err_none;
	endproperty

	a_quiet_in_reset: assert property (quiet_in_reset)
		else $error("output strobe high during reset");
	a_up_or_result: assert property (up_or_result)
		else $error("up_valid and result_valid high together");
	a_bcast_with_result: assert property (bcast_with_result)
		else $error("bcast_valid without result_valid");
	a_error_has_code: assert property (error_has_code)
		else $error("error_valid with err_none");

endmodule

bind collective_node collective_node_properties u_properties (
	.clk(clk),
	.rst_n(rst_n),
	.up_valid(up_valid),
	.result_valid(result_valid),
	.bcast_valid(bcast_valid),
	.error_valid(error_valid),
	.error_code(error_code)
);

`default_nettype wire

//--- design/collective_node.sv
`timescale 1ns/1ps
`default_nettype none

module collective_node (
	input wire logic clk,
	input wire logic rst_n,
	// Communicator load
	input wire logic comm_load,
	input wire logic [net_pkg::context_w-1:0] comm_context_id,
	input wire logic [comm_pkg::rank_w-1:0] comm_root,
	input wire logic [comm_pkg::rank_w-1:0] comm_local_rank,
	input wire logic [comm_pkg::children_w-1:0] comm_children,
	// Local processor contribution
	input wire logic local_valid,
	input wire net_pkg::collective_op_e local_op,
	input wire logic [net_pkg::context_w-1:0] local_context_id,
	input wire logic [net_pkg::seq_w-1:0] local_seq,
	input wire logic [net_pkg::payload_w-1:0] local_payload,
	// Merged child link
	input wire logic child_valid,
	input wire net_pkg::collective_op_e child_op,
	input wire logic [net_pkg::context_w-1:0] child_context_id,
	input wire logic [net_pkg::seq_w-1:0] child_seq,
	input wire logic [net_pkg::payload_w-1:0] child_payload,
	// To parent
	output logic up_valid,
	output net_pkg::collective_op_e up_op,
	output logic [net_pkg::seq_w-1:0] up_seq,
	output logic [net_pkg::payload_w-1:0] up_payload,
	// Root delivery
	output logic result_valid,
	output logic [net_pkg::seq_w-1:0] result_seq,
	output logic [net_pkg::payload_w-1:0] result_payload,
	// Allreduce broadcast packet
	output logic bcast_valid,
	output logic [net_pkg::seq_w-1:0] bcast_seq,
	output logic [net_pkg::payload_w-1:0] bcast_payload,
	output logic error_valid,
	output net_pkg::node_error_e error_code
);

	comm_ctx_if ctx_bus();
	gather_if gat_bus();

	// Context side
	comm_registry u_registry (
		.clk(clk),
		.rst_n(rst_n),
		.comm_load(comm_load),
		.comm_context_id(comm_context_id),
		.comm_root(comm_root),
		.comm_local_rank(comm_local_rank),
		.comm_children(comm_children),
		.ctx(ctx_bus.source)
	);

	// Data side
	contribution_gatherer u_gatherer (
		.clk(clk),
		.rst_n(rst_n),
		.local_valid(local_valid),
		.local_op(local_op),
		.local_context_id(local_context_id),
		.local_seq(local_seq),
		.local_payload(local_payload),
		.child_valid(child_valid),
		.child_op(child_op),
		.child_context_id(child_context_id),
		.child_seq(child_seq),
		.child_payload(child_payload),
		.gat(gat_bus.source)
	);

	// Combines both, decides and routes
	reduction_forwarder u_forwarder (
		.clk(clk),
		.rst_n(rst_n),
		.ctx(ctx_bus.sink),
		.gat(gat_bus.sink),
		.up_valid(up_valid),
		.up_op(up_op),
		.up_seq(up_seq),
		.up_payload(up_payload),
		.result_valid(result_valid),
		.result_seq(result_seq),
		.result_payload(result_payload),
		.bcast_valid(bcast_valid),
		.bcast_seq(bcast_seq),
		.bcast_payload(bcast_payload),
		.error_valid(error_valid),
		.error_code(error_code)
	);

endmodule

`default_nettype wire

//--- design/reduction_forwarder.sv
`timescale 1ns/1ps
`default_nettype none

module reduction_forwarder (
	input wire logic clk,
	input wire logic rst_n,
	comm_ctx_if.sink ctx,
	gather_if.sink gat,
	output logic up_valid,
	output net_pkg::collective_op_e up_op,
	output logic [net_pkg::seq_w-1:0] up_seq,
	output logic [net_pkg::payload_w-1:0] up_payload,
	output logic result_valid,
	output logic [net_pkg::seq_w-1:0] result_seq,
	output logic [net_pkg::payload_w-1:0] result_payload,
	output logic bcast_valid,
	output logic [net_pkg::seq_w-1:0] bcast_seq,
	output logic [net_pkg::payload_w-1:0] bcast_payload,
	output logic error_valid,
	output net_pkg::node_error_e error_code
);

	logic ctx_bad;
	logic op_ok;
	logic op_bad;
	logic [comm_pkg::count_w-1:0] target;
	logic done;
	logic is_root;
	logic emit;

	////////////////////////////////////////
	// Arrival checks
	////////////////////////////////////////

	// 1. context
	assign ctx_bad = !ctx.ctx_valid || (gat.context_id != ctx.context_id);

	// 2. opcode and consistency
	assign op_ok = (gat.op == net_pkg::op_short_reduce) ||
		(gat.op == net_pkg::op_short_allreduce);
	assign op_bad = !op_ok || gat.inconsistent;

	// 3. completion, all children plus the local processor
	assign target = {1'b0, ctx.children} + 1'b1;
	assign done = (gat.count == target);

	assign is_root = (ctx.local_rank == ctx.root);
	assign emit = gat.arrived && !ctx_bad && !op_bad && done;

	// Restart totals on any verdict
	// same cycle, so a new arrival now starts the next reduction
	assign gat.flush = gat.arrived && (ctx_bad || op_bad || done);

	////////////////////////////////////////
	// Output strobes
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			up_valid <= 1'b0;
			result_valid <= 1'b0;
			bcast_valid <= 1'b0;
			error_valid <= 1'b0;
			error_code <= net_pkg::err_none;
		end else begin
			// Non-root sends up toward the parent
			up_valid <= emit && !is_root;
			// Root delivers, allreduce also starts the downward tree
			result_valid <= emit && is_root;
			bcast_valid <= emit && is_root && (gat.op == net_pkg::op_short_allreduce);
			error_valid <= ctx.cfg_error || (gat.arrived && (ctx_bad || op_bad));
			// Arrival error wins over a config error in the same cycle
			if (gat.arrived && ctx_bad) begin
				error_code <= net_pkg::err_bad_context;
			end else if (gat.arrived && op_bad) begin
				error_code <= net_pkg::err_bad_op;
			end else if (ctx.cfg_error) begin
				error_code <= net_pkg::err_bad_config;
			end else begin
				error_code <= net_pkg::err_none;
			end
		end
	end

	// Packet fields, held until the next emit
	always_ff @(posedge clk) begin
		if (emit && !is_root) begin
			up_op <= gat.op;
			up_seq <= gat.seq;
			up_payload <= gat.sum;
		end
		if (emit && is_root) begin
			result_seq <= gat.seq;
			result_payload <= gat.sum;
		end
		// Broadcast copy of the root result
		if (emit && is_root && gat.op == net_pkg::op_short_allreduce) begin
			bcast_seq <= gat.seq;
			bcast_payload <= gat.sum;
		end
	end

endmodule

`default_nettype wire

//--- design/contribution_gatherer.sv
`timescale 1ns/1ps
`default_nettype none

module contribution_gatherer (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic local_valid,
	input wire net_pkg::collective_op_e local_op,
	input wire logic [net_pkg::context_w-1:0] local_context_id,
	input wire logic [net_pkg::seq_w-1:0] local_seq,
	input wire logic [net_pkg::payload_w-1:0] local_payload,
	input wire logic child_valid,
	input wire net_pkg::collective_op_e child_op,
	input wire logic [net_pkg::context_w-1:0] child_context_id,
	input wire logic [net_pkg::seq_w-1:0] child_seq,
	input wire logic [net_pkg::payload_w-1:0] child_payload,
	gather_if.source gat
);

	// Current totals
	logic [net_pkg::payload_w-1:0] sum_q;
	logic [comm_pkg::count_w-1:0] count_q;
	net_pkg::collective_op_e op_q;
	logic [net_pkg::seq_w-1:0] seq_q;
	logic [net_pkg::context_w-1:0] ctx_q;
	logic incon_q;
	logic arrived_q;

	// Next totals
	logic [net_pkg::payload_w-1:0] n_sum;
	logic [comm_pkg::count_w-1:0] n_count;
	net_pkg::collective_op_e n_op;
	logic [net_pkg::seq_w-1:0] n_seq;
	logic [net_pkg::context_w-1:0] n_ctx;
	logic n_incon;

	////////////////////////////////////////
	// Accumulate
	////////////////////////////////////////

	always_comb begin
		// Flush or idle starts an empty reduction
		if (gat.flush || count_q == '0) begin
			n_sum = '0;
			n_count = '0;
			n_incon = 1'b0;
		end else begin
			n_sum = sum_q;
			n_count = count_q;
			n_incon = incon_q;
		end
		n_op = op_q;
		n_seq = seq_q;
		n_ctx = ctx_q;
		// Local first, so it tags a same-cycle pair
		if (local_valid) begin
			if (n_count == '0) begin
				n_op = local_op;
				n_seq = local_seq;
				n_ctx = local_context_id;
			end else if (local_op != n_op || local_seq != n_seq || local_context_id != n_ctx) begin
				n_incon = 1'b1;
			end
			n_sum = n_sum + local_payload;
			// Saturate rather than wrap back to zero
			if (n_count != '1) begin
				n_count = n_count + 1'b1;
			end
		end
		// Child compared against whatever tagged first
		if (child_valid) begin
			if (n_count == '0) begin
				n_op = child_op;
				n_seq = child_seq;
				n_ctx = child_context_id;
			end else if (child_op != n_op || child_seq != n_seq || child_context_id != n_ctx) begin
				n_incon = 1'b1;
			end
			n_sum = n_sum + child_payload;
			if (n_count != '1) begin
				n_count = n_count + 1'b1;
			end
		end
	end

	// Sum and tags
	always_ff @(posedge clk) begin
		sum_q <= n_sum;
		op_q <= n_op;
		seq_q <= n_seq;
		ctx_q <= n_ctx;
	end

	// Count, mismatch flag, arrival strobe
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			count_q <= '0;
			incon_q <= 1'b0;
			arrived_q <= 1'b0;
		end else begin
			count_q <= n_count;
			incon_q <= n_incon;
			arrived_q <= local_valid || child_valid;
		end
	end

	assign gat.arrived = arrived_q;
	assign gat.sum = sum_q;
	assign gat.count = count_q;
	assign gat.op = op_q;
	assign gat.seq = seq_q;
	assign gat.context_id = ctx_q;
	assign gat.inconsistent = incon_q;

endmodule

`default_nettype wire

//--- design/comm_registry.sv
`timescale 1ns/1ps
`default_nettype none

module comm_registry (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic comm_load,
	input wire logic [net_pkg::context_w-1:0] comm_context_id,
	input wire logic [comm_pkg::rank_w-1:0] comm_root,
	input wire logic [comm_pkg::rank_w-1:0] comm_local_rank,
	input wire logic [comm_pkg::children_w-1:0] comm_children,
	comm_ctx_if.source ctx
);

	// Load is legal only within the torus fan-in
	logic load_ok;

	assign load_ok = (comm_children <= comm_pkg::max_children);

	// Context fields
	// Old context survives a rejected load
	always_ff @(posedge clk) begin
		if (comm_load && load_ok) begin
			ctx.context_id <= comm_context_id;
			ctx.root <= comm_root;
			ctx.local_rank <= comm_local_rank;
			ctx.children <= comm_children;
		end
	end

	// Valid flag and error strobe
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ctx.ctx_valid <= 1'b0;
			ctx.cfg_error <= 1'b0;
		end else begin
			// Sticky after the first good load
			if (comm_load && load_ok) begin
				ctx.ctx_valid <= 1'b1;
			end
			// Single cycle, same cycle as the fields would change
			ctx.cfg_error <= comm_load && !load_ok;
		end
	end

endmodule

`default_nettype wire

//--- design/collective_ifs.sv
`timescale 1ns/1ps
`default_nettype none

////////////////////////////////////////
// Communicator context bus
////////////////////////////////////////

interface comm_ctx_if;
	// Level, high once a context has been accepted
	logic ctx_valid;
	logic [net_pkg::context_w-1:0] context_id;
	logic [comm_pkg::rank_w-1:0] root;
	logic [comm_pkg::rank_w-1:0] local_rank;
	logic [comm_pkg::children_w-1:0] children;
	// Strobe for a rejected load
	logic cfg_error;

	modport source(
		output ctx_valid, context_id, root, local_rank, children, cfg_error
	);
	modport sink(
		input ctx_valid, context_id, root, local_rank, children, cfg_error
	);
endinterface

////////////////////////////////////////
// Gathered totals bus
////////////////////////////////////////

interface gather_if;
	// New totals this cycle
	logic arrived;
	logic [net_pkg::payload_w-1:0] sum;
	logic [comm_pkg::count_w-1:0] count;
	// Tags of the first arrival
	net_pkg::collective_op_e op;
	logic [net_pkg::seq_w-1:0] seq;
	logic [net_pkg::context_w-1:0] context_id;
	// Later arrival disagreed with the tags
	logic inconsistent;
	// Back from the forwarder, restart the totals
	logic flush;

	modport source(
		output arrived, sum, count, op, seq, context_id, inconsistent,
		input flush
	);
	modport sink(
		input arrived, sum, count, op, seq, context_id, inconsistent,
		output flush
	);
endinterface

`default_nettype wire

//--- design/comm_pkg.sv
`default_nettype none

package comm_pkg;

	////////////////////////////////////////
	// Communicator context
	////////////////////////////////////////

	// Rank within the communicator
	localparam int rank_w = 9;

	// Child count field of the context
	localparam int children_w = 3;

	// One child per torus direction
	// x, y and z, both signs
	localparam int max_children = 6;

	// Arrival counter
	// One bit wider than the child count, so children plus local fits
	localparam int count_w = children_w + 1;

endpackage

`default_nettype wire

//--- design/net_pkg.sv
`default_nettype none

package net_pkg;

	////////////////////////////////////////
	// Packet field widths
	////////////////////////////////////////

	// Reduction operand, one word per packet
	localparam int payload_w = 32;
	// Sequence tag of a collective call
	localparam int seq_w = 8;
	// Communicator context id carried in every packet
	localparam int context_w = 8;

	////////////////////////////////////////
	// Collective opcodes
	////////////////////////////////////////

	// Codes follow the torus packet header
	// Only the two short reductions are handled by this node
	typedef enum logic [3:0] {
		op_scan            = 4'd3,
		op_all_to_all      = 4'd4,
		op_large_bcast     = 4'd5,
		op_medium_bcast    = 4'd6,
		op_short_bcast     = 4'd7,
		op_scatter         = 4'd8,
		op_large_allgather = 4'd9,
		op_short_allgather = 4'd10,
		op_gather          = 4'd11,
		op_short_reduce    = 4'd12,
		op_large_reduce    = 4'd13,
		op_short_allreduce = 4'd14,
		op_large_allreduce = 4'd15
	} collective_op_e;

	// Error codes reported on the error strobe
	typedef enum logic [1:0] {
		err_none        = 2'd0,
		err_bad_context = 2'd1,
		err_bad_op      = 2'd2,
		err_bad_config  = 2'd3
	} node_error_e;

endpackage

`default_nettype wire
